/* Makefile */
VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= all tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* common/dcache_pkg.sv */
package dcache_pkg;

    // Direct mapped, 16 lines of 16 bytes
    localparam int DC_LINES    = 16;
    localparam int DC_INDEX_W  = 4;
    localparam int DC_OFFSET_W = 4;
    localparam int DC_TAG_W    = 24;   // 32 - index - offset

    typedef logic [127:0]          block_t;
    typedef logic [DC_TAG_W-1:0]   dc_tag_t;
    typedef logic [DC_INDEX_W-1:0] dc_index_t;

    // Miss handling FSM
    typedef enum logic [1:0] {
        DC_IDLE,
        DC_WRITEBACK,
        DC_REFILL
    } dc_state_t;

endpackage

/* common/mem_types_pkg.sv */
package mem_types_pkg;

    // Data path widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  byte_en_t;

    // Load/store width, funct3 encoding
    typedef logic [2:0]  ls_op_t;

    localparam ls_op_t LS_BYTE   = 3'b000;
    localparam ls_op_t LS_HALF   = 3'b001;
    localparam ls_op_t LS_WORD   = 3'b010;
    localparam ls_op_t LS_BYTE_U = 3'b100;
    localparam ls_op_t LS_HALF_U = 3'b101;

    // Address bit that steers an access to the I/O block
    localparam int IO_SEL_BIT = 30;

endpackage

/* dcache/dcache_array.sv */
`timescale 1ns/100ps

module dcache_array import mem_types_pkg::*, dcache_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     rd_i,
    input  logic     wr_i,
    input  logic     refill_we_i,
    input  addr_t    addr_i,
    input  ls_op_t   ls_op_i,
    input  byte_en_t byte_en_i,
    input  word_t    wdata_i,
    input  block_t   refill_block_i,
    output logic     hit_o,
    output logic     victim_dirty_o,
    output dc_tag_t  victim_tag_o,
    output block_t   victim_block_o,
    output word_t    load_data_o
);

    logic [DC_LINES-1:0] valid_q;
    logic [DC_LINES-1:0] dirty_q;
    dc_tag_t             tag_q  [DC_LINES];
    block_t              data_q [DC_LINES];

    dc_index_t index;
    dc_tag_t   tag;
    logic      tag_match;
    word_t     rd_word;
    logic [7:0]  rd_byte;
    logic [15:0] rd_half;

    assign index = addr_i[DC_OFFSET_W +: DC_INDEX_W];
    assign tag   = addr_i[31 -: DC_TAG_W];

    assign tag_match = valid_q[index] && (tag_q[index] == tag);
    assign hit_o     = (rd_i | wr_i) & tag_match;

    assign victim_dirty_o = valid_q[index] & dirty_q[index];
    assign victim_tag_o   = tag_q[index];
    assign victim_block_o = data_q[index];

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (refill_we_i) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0; // Fresh copy of memory
        end else if (wr_i && tag_match) begin
            dirty_q[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (refill_we_i) begin
            tag_q[index]  <= tag;
            data_q[index] <= refill_block_i;
        end else if (wr_i && tag_match) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en_i[i]) begin
                    data_q[index][{addr_i[3:2], 5'd0} + i*8 +: 8] <= wdata_i[i*8 +: 8];
                end
            end
        end
    end

    // Addressed word, then lane select and extension
    assign rd_word = data_q[index][{addr_i[3:2], 5'd0} +: 32];
    assign rd_byte = rd_word[{addr_i[1:0], 3'd0} +: 8];
    assign rd_half = rd_word[{addr_i[1], 4'd0} +: 16];

    always_comb begin
        case (ls_op_i)
            LS_BYTE:   load_data_o = {{24{rd_byte[7]}}, rd_byte};
            LS_BYTE_U: load_data_o = {24'd0, rd_byte};
            LS_HALF:   load_data_o = {{16{rd_half[15]}}, rd_half};
            LS_HALF_U: load_data_o = {16'd0, rd_half};
            default:   load_data_o = rd_word;
        endcase
    end

endmodule

/* dcache/dcache_ctrl.sv */
`timescale 1ns/100ps

module dcache_ctrl import mem_types_pkg::*, dcache_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    rd_i,
    input  logic    wr_i,
    input  logic    hit_i,
    input  logic    victim_dirty_i,
    input  logic    mem_ready_i,
    input  addr_t   addr_i,
    input  dc_tag_t victim_tag_i,
    input  block_t  victim_block_i,
    input  block_t  mem_rblock_i,
    output logic    busy_o,
    output logic    refill_we_o,
    output logic    mem_req_o,
    output logic    mem_we_o,
    output addr_t   mem_addr_o,
    output block_t  mem_wblock_o,
    output block_t  refill_block_o
);

    dc_state_t state_q;
    dc_state_t state_d;
    dc_index_t index;
    logic      miss;
    addr_t     victim_addr;
    addr_t     refill_addr;

    assign index = addr_i[DC_OFFSET_W +: DC_INDEX_W];
    assign miss  = (rd_i | wr_i) & ~hit_i;

    // Block aligned addresses for both directions
    assign victim_addr = {victim_tag_i, index, {DC_OFFSET_W{1'b0}}};
    assign refill_addr = {addr_i[31:DC_OFFSET_W], {DC_OFFSET_W{1'b0}}};

    always_comb begin
        state_d = state_q;
        case (state_q)
            DC_IDLE: begin
                if (miss) begin
                    if (victim_dirty_i) begin
                        state_d = DC_WRITEBACK;
                    end else begin
                        state_d = DC_REFILL;
                    end
                end
            end
            DC_WRITEBACK: begin
                if (mem_ready_i) begin
                    state_d = DC_REFILL;
                end
            end
            DC_REFILL: begin
                if (mem_ready_i) begin
                    state_d = DC_IDLE; // Line written at this edge
                end
            end
            default: state_d = DC_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= DC_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request held until the ready pulse, address fixed by state
    assign mem_req_o    = (state_q != DC_IDLE);
    assign mem_we_o     = (state_q == DC_WRITEBACK);
    assign mem_addr_o   = (state_q == DC_WRITEBACK) ? victim_addr : refill_addr;
    assign mem_wblock_o = victim_block_i;   // Victim stays put until refill

    assign refill_we_o    = (state_q == DC_REFILL) & mem_ready_i;
    assign refill_block_o = mem_rblock_i;

    // Miss cycle itself already stalls
    assign busy_o = miss | (state_q != DC_IDLE);

endmodule

/* hdl/mem_addr_decode.sv */
`timescale 1ns/100ps

module mem_addr_decode import mem_types_pkg::*; (
    input  logic     mem_read_i,
    input  logic     mem_write_i,
    input  ls_op_t   ls_op_i,
    input  addr_t    mem_addr_i,
    input  word_t    store_data_i,
    output logic     cache_rd_o,
    output logic     cache_wr_o,
    output logic     io_rd_o,
    output logic     io_wr_o,
    output byte_en_t byte_en_o,
    output word_t    store_word_o
);

    logic is_io;

    assign is_io = mem_addr_i[IO_SEL_BIT];

    assign cache_rd_o = mem_read_i  & ~is_io;
    assign cache_wr_o = mem_write_i & ~is_io;
    assign io_rd_o    = mem_read_i  &  is_io;
    assign io_wr_o    = mem_write_i &  is_io;

    // Lane enables and replicated store data from the width code
    always_comb begin
        case (ls_op_i[1:0])
            2'b00: begin // byte
                byte_en_o    = 4'b0001 << mem_addr_i[1:0];
                store_word_o = {4{store_data_i[7:0]}};
            end
            2'b01: begin // half
                byte_en_o    = mem_addr_i[1] ? 4'b1100 : 4'b0011;
                store_word_o = {2{store_data_i[15:0]}};
            end
            default: begin
                byte_en_o    = 4'b1111;
                store_word_o = store_data_i;
            end
        endcase
    end

endmodule

/* hdl/mem_result.sv */
`timescale 1ns/100ps

module mem_result import mem_types_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     stall_i,
    input  logic     is_load_i,
    input  logic     is_io_i,
    input  logic     reg_write_i,
    input  reg_idx_t rd_i,
    input  word_t    rd_data_i,
    input  word_t    cache_data_i,
    input  word_t    io_data_i,
    output logic     reg_write_o,
    output reg_idx_t rd_o,
    output word_t    wb_data_o
);

    logic     reg_write_q;
    reg_idx_t rd_q;
    word_t    wb_data_q;
    word_t    wb_data_d;

    // Load data replaces the register result
    always_comb begin
        if (is_load_i) begin
            wb_data_d = is_io_i ? io_data_i : cache_data_i;
        end else begin
            wb_data_d = rd_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            reg_write_q <= 1'b0;
        end else begin
            reg_write_q <= reg_write_i & ~stall_i;  // Bubble while stalled
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            rd_q      <= rd_i;
            wb_data_q <= wb_data_d;
        end
    end

    assign reg_write_o = reg_write_q;
    assign rd_o        = rd_q;
    assign wb_data_o   = wb_data_q;

endmodule

/* hdl/mem_stage.sv */
`timescale 1ns/100ps

module mem_stage import mem_types_pkg::*, dcache_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     mem_read_i,
    input  logic     mem_write_i,
    input  ls_op_t   ls_op_i,
    input  addr_t    mem_addr_i,
    input  word_t    store_data_i,
    input  logic     reg_write_i,
    input  reg_idx_t rd_i,
    input  word_t    rd_data_i,
    output logic     mem_req_o,
    output logic     mem_we_o,
    output addr_t    mem_addr_o,
    output block_t   mem_wblock_o,
    input  block_t   mem_rblock_i,
    input  logic     mem_ready_i,
    output logic     reg_write_o,
    output reg_idx_t rd_o,
    output word_t    wb_data_o,
    output logic     stall_o,
    output logic     pwm_o
);

    logic     cache_rd, cache_wr;
    logic     io_rd, io_wr;
    byte_en_t byte_en;
    word_t    store_word;
    logic     hit, victim_dirty;
    dc_tag_t  victim_tag;
    block_t   victim_block;
    block_t   refill_block;
    logic     refill_we;
    logic     ctrl_busy;
    logic     io_stall;
    word_t    io_rdata;
    word_t    load_data;

    mem_addr_decode i_decode (
        .mem_read_i(mem_read_i), .mem_write_i(mem_write_i), .ls_op_i(ls_op_i),
        .mem_addr_i(mem_addr_i), .store_data_i(store_data_i),
        .cache_rd_o(cache_rd), .cache_wr_o(cache_wr), .io_rd_o(io_rd), .io_wr_o(io_wr),
        .byte_en_o(byte_en), .store_word_o(store_word)
    );

    dcache_array i_array (
        .clk_i(clk_i), .rst_i(rst_i), .rd_i(cache_rd), .wr_i(cache_wr),
        .refill_we_i(refill_we), .addr_i(mem_addr_i), .ls_op_i(ls_op_i),
        .byte_en_i(byte_en), .wdata_i(store_word), .refill_block_i(refill_block),
        .hit_o(hit), .victim_dirty_o(victim_dirty), .victim_tag_o(victim_tag),
        .victim_block_o(victim_block), .load_data_o(load_data)
    );

    dcache_ctrl i_ctrl (
        .clk_i(clk_i), .rst_i(rst_i), .rd_i(cache_rd), .wr_i(cache_wr), .hit_i(hit),
        .victim_dirty_i(victim_dirty), .mem_ready_i(mem_ready_i), .addr_i(mem_addr_i),
        .victim_tag_i(victim_tag), .victim_block_i(victim_block),
        .mem_rblock_i(mem_rblock_i), .busy_o(ctrl_busy), .refill_we_o(refill_we),
        .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
        .mem_wblock_o(mem_wblock_o), .refill_block_o(refill_block)
    );

    pwm_io i_pwm (
        .clk_i(clk_i), .rst_i(rst_i), .rd_i(io_rd), .wr_i(io_wr), .addr_i(mem_addr_i),
        .wdata_i(store_word), .stall_o(io_stall), .rdata_o(io_rdata), .pwm_o(pwm_o)
    );

    assign stall_o = ctrl_busy | io_stall;  // Miss in progress or first I/O cycle

    mem_result i_result (
        .clk_i(clk_i), .rst_i(rst_i), .stall_i(stall_o), .is_load_i(mem_read_i),
        .is_io_i(io_rd), .reg_write_i(reg_write_i), .rd_i(rd_i), .rd_data_i(rd_data_i),
        .cache_data_i(load_data), .io_data_i(io_rdata),
        .reg_write_o(reg_write_o), .rd_o(rd_o), .wb_data_o(wb_data_o)
    );

endmodule

/* hdl/pwm_io.sv */
`timescale 1ns/100ps

module pwm_io import mem_types_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  rd_i,
    input  logic  wr_i,
    input  addr_t addr_i,
    input  word_t wdata_i,
    output logic  stall_o,
    output word_t rdata_o,
    output logic  pwm_o
);

    logic  phase_q;     // Set during the stalled first cycle
    word_t period_q;
    word_t duty_q;
    word_t cnt_q;
    logic  pwm_q;

    assign stall_o = (rd_i | wr_i) & ~phase_q;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            phase_q  <= 1'b0;
            period_q <= '0;
            duty_q   <= '0;
            cnt_q    <= '0;
            pwm_q    <= 1'b0;
        end else begin
            phase_q <= (rd_i | wr_i) & ~phase_q;
            if (wr_i && phase_q) begin
                case (addr_i[3:2])
                    2'd0:    period_q <= wdata_i;
                    2'd1:    duty_q   <= wdata_i;
                    default: ;  // Counter is read only
                endcase
            end
            cnt_q <= (cnt_q + 1'b1 >= period_q) ? '0 : cnt_q + 1'b1;
            pwm_q <= (cnt_q < duty_q);
        end
    end

    always_comb begin
        case (addr_i[3:2])
            2'd0:    rdata_o = period_q;
            2'd1:    rdata_o = duty_q;
            2'd2:    rdata_o = cnt_q;
            default: rdata_o = '0;
        endcase
    end

    assign pwm_o = pwm_q;

endmodule

/* src.f */
common/mem_types_pkg.sv
common/dcache_pkg.sv
hdl/mem_addr_decode.sv
dcache/dcache_ctrl.sv
dcache/dcache_array.sv
hdl/pwm_io.sv
hdl/mem_result.sv
hdl/mem_stage.sv
tb/mem_stage_chk.sv
tb/mem_stage_tb.sv

/* tb/mem_stage_chk.sv */
`timescale 1ns/100ps

module mem_stage_chk import mem_types_pkg::*; (
    input logic  clk_i,
    input logic  rst_i,
    input logic  mem_req_o,
    input logic  mem_we_o,
    input addr_t mem_addr_o,
    input logic  mem_ready_i,
    input logic  stall_o,
    input logic  reg_write_o
);

    // Controller comes out of reset idle
    assert property (@(posedge clk_i) !rst_i |=> !mem_req_o)
        else $error("mem_req_o high after reset");

    // Request, direction and block address hold until ready
    assert property (@(posedge clk_i) disable iff (!rst_i)
        mem_req_o && !mem_ready_i |=> mem_req_o && $stable(mem_addr_o) && $stable(mem_we_o))
        else $error("memory request changed before mem_ready_i");

    assert property (@(posedge clk_i) disable iff (!rst_i) stall_o |=> !reg_write_o)
        else $error("reg_write_o high after a stalled edge");  // Bubble expected

endmodule

bind mem_stage mem_stage_chk i_chk (.*);

/* tb/mem_stage_stimulus.txt */
// id op width addr data expect, all hex; width is the funct3 code
// op: 0 alu, 1 load, 2 store, 3 no reg write, 4 count pwm_o high over data cycles, 5 memory writes
01 2 2 00000100 12345678 00000000
02 1 2 00000100 00000000 12345678
03 1 2 00000104 00000000 FFFFFEFB
04 2 0 00000109 000000A5 00000000
05 2 0 0000010A 0000003C 00000000
06 1 2 00000108 00000000 FF3CA5F7
07 1 0 00000109 00000000 FFFFFFA5
08 1 4 00000109 00000000 000000A5
09 1 1 0000010A 00000000 FFFFFF3C
0A 1 5 0000010A 00000000 0000FF3C
0B 2 1 0000010C 00001234 00000000
0C 1 5 0000010C 00000000 00001234
0D 1 2 00000200 00000000 FFFFFDFF
0E 5 0 00000100 00000000 00000001
0F 1 2 00000100 00000000 12345678
10 1 2 00000108 00000000 FF3CA5F7
11 0 0 00000000 CAFEF00D CAFEF00D
12 3 0 00000000 DEADBEEF 00000000
13 2 2 40000000 0000000A 00000000
14 2 2 40000004 00000003 00000000
15 1 2 40000004 00000000 00000003
16 4 0 00000000 00000014 00000006
FF F 0 00000000 00000000 00000000

/* tb/mem_stage_tb.sv */
`timescale 1ns/100ps

module mem_stage_tb import mem_types_pkg::*, dcache_pkg::*; ();

    logic     clk_i;
    logic     rst_i;
    logic     mem_read_i;
    logic     mem_write_i;
    ls_op_t   ls_op_i;
    addr_t    mem_addr_i;
    word_t    store_data_i;
    logic     reg_write_i;
    reg_idx_t rd_i;
    word_t    rd_data_i;
    logic     mem_req_o;
    logic     mem_we_o;
    addr_t    mem_addr_o;
    block_t   mem_wblock_o;
    block_t   mem_rblock_i = '0;
    logic     mem_ready_i = 1'b0;
    logic     reg_write_o;
    reg_idx_t rd_o;
    word_t    wb_data_o;
    logic     stall_o;
    logic     pwm_o;

    word_t    stim [6*64];          // id, op, width, addr, data, expect
    block_t   mem_model [addr_t];   // Main memory keyed by block address
    int       num_tests;
    int       cycle_count = 0;
    int       cycle_limit = 0;
    int       errors;
    int       mem_writes = 0;
    addr_t    last_write_addr = '0;
    logic     serving = 1'b0;
    int       delay_left = 0;
    logic     test_failed;

    logic [DC_LINES-1:0] line_valid = '0;   // Blocks the cache should hold
    addr_t               line_block [DC_LINES];

    mem_stage i_dut (.*);

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    // Untouched memory reads back the inverse of each word's byte address
    function automatic block_t fill_block(input addr_t base);
        block_t blk;
        for (int i = 0; i < 4; i++) begin
            blk[i*32 +: 32] = ~(base + addr_t'(i*4));
        end
        return blk;
    endfunction

    // Ready comes 1 to 4 cycles after the request is seen
    always @(negedge clk_i) begin
        if (mem_ready_i) begin
            mem_ready_i <= 1'b0;
        end else if (mem_req_o) begin
            if (!serving) begin
                serving    = 1'b1;
                delay_left = $urandom_range(3, 0);
            end
            if (delay_left == 0) begin
                serving = 1'b0;
                if (mem_we_o) begin
                    mem_model[mem_addr_o] = mem_wblock_o;
                    mem_writes++;
                    last_write_addr = mem_addr_o;
                end else if (mem_model.exists(mem_addr_o)) begin
                    mem_rblock_i <= mem_model[mem_addr_o];
                end else begin
                    mem_rblock_i <= fill_block(mem_addr_o);
                end
                mem_ready_i <= 1'b1;
            end else begin
                delay_left--;
            end
        end
    end

    task automatic compare_value(input string name, input word_t got, input word_t exp);
        assert (got == exp) else begin
            $display("ERROR %0t %s: got %h, expected %h", $time, name, got, exp);
            errors++;
            test_failed = 1'b1;
        end
    endtask

    // Hit or miss follows from the blocks touched so far
    task automatic check_cache_stall(input addr_t addr, input int stalls);
        int    line;
        addr_t blk;
        line = int'(addr[7:4]);
        blk  = {addr[31:4], 4'h0};
        if (line_valid[line] && line_block[line] == blk) begin
            compare_value("hit_stall_cycles", word_t'(stalls), 32'd0);
        end else begin
            assert (stalls > 0) else begin
                $display("cache miss at address %h did not raise stall_o at %0t", addr, $time);
                errors++;
                test_failed = 1'b1;
            end
        end
        line_valid[line] = 1'b1;
        line_block[line] = blk;
    endtask

    task automatic drive_idle();
        mem_read_i   = 1'b0;
        mem_write_i  = 1'b0;
        reg_write_i  = 1'b0;
        ls_op_i      = LS_WORD;
        mem_addr_i   = '0;
        store_data_i = '0;
        rd_i         = '0;
        rd_data_i    = '0;
    endtask

    // Runs from one falling edge to the falling edge after write-back
    task automatic run_access(input int base, output int stalls);
        word_t op;
        op           = stim[base+1];
        mem_read_i   = (op == 1);
        mem_write_i  = (op == 2);
        reg_write_i  = (op == 0) || (op == 1);
        ls_op_i      = ls_op_t'(stim[base+2]);
        mem_addr_i   = stim[base+3];
        store_data_i = stim[base+4];
        rd_data_i    = stim[base+4];
        rd_i         = reg_idx_t'(stim[base]);
        stalls       = 0;
        #1;
        while (stall_o) begin
            stalls++;
            @(negedge clk_i);
            #1;
        end
        @(negedge clk_i);
    endtask

    function automatic string op_name(input word_t op);
        case (op)
            0:       return "alu";
            1:       return "load";
            2:       return "store";
            3:       return "nop";
            4:       return "pwm";
            default: return "memw";
        endcase
    endfunction

    initial begin
        word_t op;
        int    base;
        int    stalls;
        int    high;
        void'($urandom(91675));
        clk_i  = 1'b0;
        rst_i  = 1'b0;
        errors = 0;
        drive_idle();
        for (int i = 0; i < 6*64; i++) begin
            stim[i] = 32'hF;    // Reads as end marker
        end
        $readmemh("tb/mem_stage_stimulus.txt", stim);
        num_tests = 0;
        while (num_tests < 64 && stim[6*num_tests+1] != 32'hF) begin
            num_tests++;
        end
        if (num_tests == 0) begin
            $display("stimulus file holds no tests");
            errors++;
        end
        cycle_limit = 40 * num_tests + 10;
        repeat (10) @(negedge clk_i);
        rst_i = 1'b1;
        for (int t = 0; t < num_tests; t++) begin
            base        = 6 * t;
            op          = stim[base+1];
            test_failed = 1'b0;
            if (op == 4) begin
                drive_idle();
                high = 0;
                repeat (stim[base+4]) begin
                    @(negedge clk_i);
                    if (pwm_o) begin
                        high++;
                    end
                end
                compare_value("pwm_high_cycles", word_t'(high), stim[base+5]);
            end else if (op == 5) begin
                compare_value("mem_write_count", word_t'(mem_writes), stim[base+5]);
                compare_value("mem_last_write_addr", last_write_addr, stim[base+3]);
            end else begin
                run_access(base, stalls);
                if (op == 1 || op == 2) begin
                    if (stim[base+3][IO_SEL_BIT]) begin
                        compare_value("io_stall_cycles", word_t'(stalls), 32'd1);
                    end else begin
                        check_cache_stall(stim[base+3], stalls);
                    end
                end
                compare_value("reg_write_o", word_t'(reg_write_o), word_t'(op <= 1));
                if (op <= 1) begin
                    compare_value("rd_o", word_t'(rd_o), word_t'(reg_idx_t'(stim[base])));
                    compare_value("wb_data_o", wb_data_o, stim[base+5]);
                end
            end
            $display("test %0h %s: %s", stim[base], op_name(op), test_failed ? "FAIL" : "ok");
        end
        $display("summary: %0d tests run, %0d checks wrong", num_tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
